//--- common/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

   // Bus widths
   localparam int DAT_WIDTH = 32;
   localparam int ADR_WIDTH = 32;
   localparam int SEL_WIDTH = DAT_WIDTH / 8;

   // Address map
   localparam int MATCH_WIDTH = 8;
   localparam int RAM_ADR_WIDTH = 12;
   localparam int RAM_WORDS = 1024;
   localparam int RAM_IDX_WIDTH = 10;
   localparam logic [MATCH_WIDTH-1:0] SCRATCH_MATCH = 8'h91;
   localparam logic [MATCH_WIDTH-1:0] EXT_MATCH = 8'h92;

   // Scratch slave register count, offset 3 is the timeout counter
   localparam int SCR_REGS = 3;

   // Response watchdog
   localparam int WDOG_LIMIT = 64;
   localparam int WDOG_CNT_WIDTH = 7;

   // Arbiter owner encoding
   localparam logic [1:0] OWN_NONE = 2'd0;
   localparam logic [1:0] OWN_M0 = 2'd1;
   localparam logic [1:0] OWN_M1 = 2'd2;

   typedef struct packed {
      logic [ADR_WIDTH-1:0] adr;
      logic [DAT_WIDTH-1:0] dat;
      logic [SEL_WIDTH-1:0] sel;
      logic                 we;
      logic                 cyc;
      logic                 stb;
   } wb_req_t;

   typedef struct packed {
      logic [DAT_WIDTH-1:0] dat;
      logic                 ack;
      logic                 err;
      logic                 rty;
   } wb_rsp_t;

   // High byte match view for the scratch and external regions
   typedef struct packed {
      logic [MATCH_WIDTH-1:0]           match;
      logic [ADR_WIDTH-MATCH_WIDTH-1:0] offset;
   } dbus_region_t;

   // Low view for the RAM, which sits at the bottom of the map
   typedef struct packed {
      logic [ADR_WIDTH-RAM_ADR_WIDTH-1:0] hi;
      logic [RAM_ADR_WIDTH-1:0]           ram_offset;
   } dbus_low_t;

   typedef union packed {
      dbus_region_t region;
      dbus_low_t    low;
   } dbus_addr_u;

   // One-hot slave select
   typedef struct packed {
      logic ram;
      logic scr;
      logic ext;
      logic none;
   } dbus_sel_t;

endpackage

`default_nettype wire

//--- dbus_interconnect/dbus_arbiter.sv
`default_nettype none

module dbus_arbiter (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  dbus_pkg::wb_req_t m0_req_i,
   input  dbus_pkg::wb_req_t m1_req_i,
   output dbus_pkg::wb_rsp_t m0_rsp_o,
   output dbus_pkg::wb_rsp_t m1_rsp_o,
   output dbus_pkg::wb_req_t bus_req_o,
   input  dbus_pkg::wb_rsp_t bus_rsp_i
);

   logic [1:0] owner_q;
   logic       own_m0;
   logic       own_m1;

   // Grant lock, debug master wins when both ask at once
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         owner_q <= dbus_pkg::OWN_NONE;
      end else begin
         case (owner_q)
            dbus_pkg::OWN_M0: begin
               if (!m0_req_i.cyc)
                  owner_q <= dbus_pkg::OWN_NONE;
            end
            dbus_pkg::OWN_M1: begin
               if (!m1_req_i.cyc)
                  owner_q <= dbus_pkg::OWN_NONE;
            end
            default: begin
               if (m1_req_i.cyc)
                  owner_q <= dbus_pkg::OWN_M1;
               else if (m0_req_i.cyc)
                  owner_q <= dbus_pkg::OWN_M0;
            end
         endcase
      end
   end

   assign own_m0 = (owner_q == dbus_pkg::OWN_M0);
   assign own_m1 = (owner_q == dbus_pkg::OWN_M1);

   // Idle bus carries an all-zero request
   always_comb begin
      if (own_m1)
         bus_req_o = m1_req_i;
      else if (own_m0)
         bus_req_o = m0_req_i;
      else
         bus_req_o = '0;
   end

   // Data goes to both, handshake only to the owner
   always_comb begin
      m0_rsp_o     = bus_rsp_i;
      m0_rsp_o.ack = bus_rsp_i.ack & own_m0;
      m0_rsp_o.err = bus_rsp_i.err & own_m0;
      m0_rsp_o.rty = bus_rsp_i.rty & own_m0;
      m1_rsp_o     = bus_rsp_i;
      m1_rsp_o.ack = bus_rsp_i.ack & own_m1;
      m1_rsp_o.err = bus_rsp_i.err & own_m1;
      m1_rsp_o.rty = bus_rsp_i.rty & own_m1;
   end

endmodule

`default_nettype wire

//--- dbus_interconnect/dbus_decoder.sv
`default_nettype none

module dbus_decoder (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  dbus_pkg::wb_req_t bus_req_i,
   output dbus_pkg::wb_rsp_t bus_rsp_o,
   output dbus_pkg::wb_req_t ram_req_o,
   output dbus_pkg::wb_req_t scr_req_o,
   output dbus_pkg::wb_req_t ext_req_o,
   input  dbus_pkg::wb_rsp_t ram_rsp_i,
   input  dbus_pkg::wb_rsp_t scr_rsp_i,
   input  dbus_pkg::wb_rsp_t ext_rsp_i
);

   dbus_pkg::dbus_addr_u addr;
   dbus_pkg::dbus_sel_t  sel_d;
   dbus_pkg::dbus_sel_t  sel_q;
   logic                 unmapped_err_q;

   // Pass the request through with cyc and stb masked by the select
   function automatic dbus_pkg::wb_req_t gate_req(input dbus_pkg::wb_req_t req,
                                                  input logic en);
      dbus_pkg::wb_req_t r;
      r     = req;
      r.cyc = req.cyc & en;
      r.stb = req.stb & en;
      return r;
   endfunction

   assign addr = bus_req_i.adr;

   // RAM needs all bits above its span clear, the others match the top byte
   always_comb begin
      sel_d.ram  = (addr.low.hi == '0);
      sel_d.scr  = (addr.region.match == dbus_pkg::SCRATCH_MATCH);
      sel_d.ext  = (addr.region.match == dbus_pkg::EXT_MATCH);
      sel_d.none = ~(sel_d.ram | sel_d.scr | sel_d.ext);
   end

   // Select only follows a strobed address, so an idle bus selects nothing
   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         sel_q <= '0;
      else if (bus_req_i.stb)
         sel_q <= sel_d;
      else
         sel_q <= '0;
   end

   // Unmapped access gets a single err cycle
   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         unmapped_err_q <= 1'b0;
      else
         unmapped_err_q <= sel_q.none & bus_req_i.stb & ~unmapped_err_q;
   end

   assign ram_req_o = gate_req(bus_req_i, sel_q.ram);
   assign scr_req_o = gate_req(bus_req_i, sel_q.scr);
   assign ext_req_o = gate_req(bus_req_i, sel_q.ext);

   // Response merge
   always_comb begin
      if (sel_q.ram)
         bus_rsp_o.dat = ram_rsp_i.dat;
      else if (sel_q.scr)
         bus_rsp_o.dat = scr_rsp_i.dat;
      else if (sel_q.ext)
         bus_rsp_o.dat = ext_rsp_i.dat;
      else
         bus_rsp_o.dat = '0;
      bus_rsp_o.ack = (ram_rsp_i.ack & sel_q.ram) | (scr_rsp_i.ack & sel_q.scr) |
                      (ext_rsp_i.ack & sel_q.ext);
      bus_rsp_o.err = (ram_rsp_i.err & sel_q.ram) | (scr_rsp_i.err & sel_q.scr) |
                      (ext_rsp_i.err & sel_q.ext) | unmapped_err_q;
      bus_rsp_o.rty = (ram_rsp_i.rty & sel_q.ram) | (scr_rsp_i.rty & sel_q.scr) |
                      (ext_rsp_i.rty & sel_q.ext);
   end

endmodule

`default_nettype wire

//--- dbus_interconnect/dbus_watchdog.sv
`default_nettype none

module dbus_watchdog (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  dbus_pkg::wb_req_t bus_req_i,
   input  dbus_pkg::wb_rsp_t bus_rsp_i,
   output dbus_pkg::wb_rsp_t rsp_o,
   output logic              timeout_o
);

   logic                                stb_q;
   logic [dbus_pkg::WDOG_CNT_WIDTH-1:0] cnt_q;
   logic                                any_rsp;
   logic                                stb_edge;
   logic                                expired;

   assign any_rsp  = bus_rsp_i.ack | bus_rsp_i.err | bus_rsp_i.rty;
   assign stb_edge = bus_req_i.stb & ~stb_q;
   // A real response in the limit cycle wins over the timeout
   assign expired  = (cnt_q == dbus_pkg::WDOG_LIMIT) & ~any_rsp;

   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         stb_q <= 1'b0;
      else
         stb_q <= bus_req_i.stb;
   end

   // Zero means idle, a strobe edge starts the count at one
   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         cnt_q <= '0;
      else if (any_rsp || expired)
         cnt_q <= '0;
      else if (stb_edge)
         cnt_q <= 1;
      else if (cnt_q != '0)
         cnt_q <= cnt_q + 1'b1;
   end

   always_comb begin
      rsp_o     = bus_rsp_i;
      rsp_o.err = bus_rsp_i.err | expired;
   end

   assign timeout_o = expired;

endmodule

`default_nettype wire

//--- verilog/wb_ram_slave.sv
`default_nettype none

module wb_ram_slave (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  dbus_pkg::wb_req_t req_i,
   output dbus_pkg::wb_rsp_t rsp_o
);

   logic [dbus_pkg::DAT_WIDTH-1:0]     mem [0:dbus_pkg::RAM_WORDS-1];
   logic [dbus_pkg::DAT_WIDTH-1:0]     rdat_q;
   logic [dbus_pkg::RAM_IDX_WIDTH-1:0] word_idx;
   dbus_pkg::dbus_addr_u               addr;
   logic                               ack_q;
   logic                               access;

   assign addr     = req_i.adr;
   // Word index drops the byte lane bits
   assign word_idx = addr.low.ram_offset[dbus_pkg::RAM_ADR_WIDTH-1:2];
   // No new access in the ack cycle, the master still holds stb there
   assign access   = req_i.cyc & req_i.stb & ~ack_q;

   // Byte lane writes
   always_ff @(posedge wb_clk) begin
      if (access && req_i.we) begin
         for (int i = 0; i < dbus_pkg::SEL_WIDTH; i++) begin
            if (req_i.sel[i])
               mem[word_idx][8*i +: 8] <= req_i.dat[8*i +: 8];
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      rdat_q <= mem[word_idx];
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   assign rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0, rty: 1'b0};

endmodule

`default_nettype wire

//--- verilog/wb_scratch_slave.sv
`default_nettype none

module wb_scratch_slave (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  dbus_pkg::wb_req_t req_i,
   output dbus_pkg::wb_rsp_t rsp_o,
   input  logic              timeout_i
);

   logic [dbus_pkg::DAT_WIDTH-1:0] scr_q [0:dbus_pkg::SCR_REGS-1];
   logic [dbus_pkg::DAT_WIDTH-1:0] tmo_cnt_q;
   logic [dbus_pkg::DAT_WIDTH-1:0] rdat_q;
   dbus_pkg::dbus_addr_u           addr;
   logic [1:0]                     word_idx;
   logic                           ack_q;
   logic                           access;

   assign addr     = req_i.adr;
   assign word_idx = addr.region.offset[3:2];
   assign access   = req_i.cyc & req_i.stb & ~ack_q;

   // Offset 3 is not writable, such writes still get their ack
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         for (int r = 0; r < dbus_pkg::SCR_REGS; r++)
            scr_q[r] <= '0;
      end else if (access && req_i.we && (word_idx < dbus_pkg::SCR_REGS)) begin
         for (int i = 0; i < dbus_pkg::SEL_WIDTH; i++) begin
            if (req_i.sel[i])
               scr_q[word_idx][8*i +: 8] <= req_i.dat[8*i +: 8];
         end
      end
   end

   // Saturating count of watchdog timeouts
   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         tmo_cnt_q <= '0;
      else if (timeout_i && !(&tmo_cnt_q))
         tmo_cnt_q <= tmo_cnt_q + 1'b1;
   end

   always_ff @(posedge wb_clk) begin
      case (word_idx)
         2'd0:    rdat_q <= scr_q[0];
         2'd1:    rdat_q <= scr_q[1];
         2'd2:    rdat_q <= scr_q[2];
         default: rdat_q <= tmo_cnt_q;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   assign rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0, rty: 1'b0};

endmodule

`default_nettype wire

//--- verilog/dbus_subsystem.sv
`default_nettype none

module dbus_subsystem (
   input  logic              wb_clk,
   input  logic              wb_rst,
   // Processor data master
   input  dbus_pkg::wb_req_t m0_req_i,
   output dbus_pkg::wb_rsp_t m0_rsp_o,
   // Debug master
   input  dbus_pkg::wb_req_t m1_req_i,
   output dbus_pkg::wb_rsp_t m1_rsp_o,
   // External slave port
   output dbus_pkg::wb_req_t ext_req_o,
   input  dbus_pkg::wb_rsp_t ext_rsp_i
);

   dbus_pkg::wb_req_t bus_req;
   dbus_pkg::wb_rsp_t bus_rsp;
   // Decoder response with the watchdog err merged in
   dbus_pkg::wb_rsp_t fabric_rsp;
   dbus_pkg::wb_req_t ram_req;
   dbus_pkg::wb_rsp_t ram_rsp;
   dbus_pkg::wb_req_t scr_req;
   dbus_pkg::wb_rsp_t scr_rsp;
   logic              wdog_pulse;

   dbus_arbiter dbus_arbiter_inst (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .m0_req_i  (m0_req_i),
      .m1_req_i  (m1_req_i),
      .m0_rsp_o  (m0_rsp_o),
      .m1_rsp_o  (m1_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (fabric_rsp)
   );

   dbus_decoder dbus_decoder_inst (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .ram_req_o (ram_req),
      .scr_req_o (scr_req),
      .ext_req_o (ext_req_o),
      .ram_rsp_i (ram_rsp),
      .scr_rsp_i (scr_rsp),
      .ext_rsp_i (ext_rsp_i)
   );

   dbus_watchdog dbus_watchdog_inst (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .bus_req_i (bus_req),
      .bus_rsp_i (bus_rsp),
      .rsp_o     (fabric_rsp),
      .timeout_o (wdog_pulse)
   );

   wb_ram_slave wb_ram_slave_inst (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .req_i  (ram_req),
      .rsp_o  (ram_rsp)
   );

   wb_scratch_slave wb_scratch_slave_inst (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .req_i     (scr_req),
      .rsp_o     (scr_rsp),
      .timeout_i (wdog_pulse)
   );

endmodule

`default_nettype wire

//--- testbench/dbus_subsystem_asserts.sv
`default_nettype none

module dbus_subsystem_asserts (
   input logic              wb_clk,
   input logic              wb_rst,
   input dbus_pkg::wb_rsp_t m0_rsp_i,
   input dbus_pkg::wb_rsp_t m1_rsp_i,
   input dbus_pkg::wb_req_t ext_req_i
);

   // Failure count, read by the testbench at the end of the run
   int   fail_cnt = 0;
   logic m0_any;
   logic m1_any;

   assign m0_any = m0_rsp_i.ack | m0_rsp_i.err | m0_rsp_i.rty;
   assign m1_any = m1_rsp_i.ack | m1_rsp_i.err | m1_rsp_i.rty;

   m0_ack_err: assert property (@(posedge wb_clk) disable iff (wb_rst)
                                !(m0_rsp_i.ack && m0_rsp_i.err))
      else begin
         $error("master 0 got ack and err in the same cycle");
         fail_cnt++;
      end

   m1_ack_err: assert property (@(posedge wb_clk) disable iff (wb_rst)
                                !(m1_rsp_i.ack && m1_rsp_i.err))
      else begin
         $error("master 1 got ack and err in the same cycle");
         fail_cnt++;
      end

   // Only the grant owner may see a handshake
   one_owner: assert property (@(posedge wb_clk) disable iff (wb_rst) !(m0_any && m1_any))
      else begin
         $error("both masters got a response in the same cycle");
         fail_cnt++;
      end

   ext_stb_cyc: assert property (@(posedge wb_clk) disable iff (wb_rst)
                                 ext_req_i.stb |-> ext_req_i.cyc)
      else begin
         $error("external stb without cyc");
         fail_cnt++;
      end

endmodule

bind dbus_subsystem dbus_subsystem_asserts dbus_subsystem_asserts_inst (
   .wb_clk    (wb_clk),
   .wb_rst    (wb_rst),
   .m0_rsp_i  (m0_rsp_o),
   .m1_rsp_i  (m1_rsp_o),
   .ext_req_i (ext_req_o)
);

`default_nettype wire

//--- testbench/tb_dbus_subsystem.sv
`default_nettype none

module tb_dbus_subsystem;

   typedef struct {
      int          master;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        exp_err;
      logic [31:0] exp_dat;
      // Starts in the same cycle as the next row
      logic        pair;
   } step_t;

   logic              wb_clk;
   logic              wb_rst;
   dbus_pkg::wb_req_t m0_req;
   dbus_pkg::wb_req_t m1_req;
   dbus_pkg::wb_rsp_t m0_rsp;
   dbus_pkg::wb_rsp_t m1_rsp;
   dbus_pkg::wb_req_t ext_req;
   dbus_pkg::wb_rsp_t ext_rsp;
   // Last strobed request seen by the external slave model
   dbus_pkg::wb_req_t ext_seen;

   step_t       steps[$];
   logic [31:0] shadow_ram [0:dbus_pkg::RAM_WORDS-1];
   logic [31:0] shadow_scr [0:2];
   logic [31:0] shadow_tmo;
   logic [31:0] lcg_state;
   int          mismatch_cnt;
   int          timeout_cnt;

   dbus_subsystem dbus_subsystem_inst (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .m0_req_i  (m0_req),
      .m0_rsp_o  (m0_rsp),
      .m1_req_i  (m1_req),
      .m1_rsp_o  (m1_rsp),
      .ext_req_o (ext_req),
      .ext_rsp_i (ext_rsp)
   );

   initial begin : clock_gen
      wb_clk = 1'b0;
      forever begin
         #50;
         wb_clk = ~wb_clk;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  sel);
      logic [31:0] r;
      r = old_w;
      for (int i = 0; i < 4; i++) begin
         if (sel[i])
            r[8*i +: 8] = new_w[8*i +: 8];
      end
      return r;
   endfunction

   // Append one row and predict its response from the shadow state
   task automatic add_step(input int m, input logic we, input logic [31:0] adr,
                           input logic [3:0] sel, input logic pair);
      step_t s;
      s = '{m, we, adr, 32'h0, sel, 1'b0, 32'h0, pair};
      if (we) begin
         lcg_state = lcg_next(lcg_state);
         s.dat = lcg_state;
      end
      if (adr[31:dbus_pkg::RAM_ADR_WIDTH] == '0) begin
         if (we)
            shadow_ram[adr[11:2]] = merge_bytes(shadow_ram[adr[11:2]], s.dat, sel);
         s.exp_dat = shadow_ram[adr[11:2]];
      end else if (adr[31:24] == dbus_pkg::SCRATCH_MATCH) begin
         if (adr[3:2] == 2'd3) begin
            s.exp_dat = shadow_tmo;
         end else begin
            if (we)
               shadow_scr[adr[3:2]] = merge_bytes(shadow_scr[adr[3:2]], s.dat, sel);
            s.exp_dat = shadow_scr[adr[3:2]];
         end
      end else if (adr[31:24] == dbus_pkg::EXT_MATCH) begin
         // Offset bit 23 makes the external model silent
         s.exp_err = adr[23];
         if (adr[23])
            shadow_tmo = shadow_tmo + 1;
         s.exp_dat = adr ^ 32'h5a5a0000;
      end else begin
         s.exp_err = 1'b1;
      end
      steps.push_back(s);
   endtask

   task automatic build_table();
      // RAM full words, byte merges, read back
      add_step(0, 1, 32'h0000_0100, 4'hf, 0);
      add_step(1, 1, 32'h0000_0100, 4'b0101, 0);
      add_step(0, 0, 32'h0000_0100, 4'hf, 0);
      add_step(1, 1, 32'h0000_0ea4, 4'hf, 0);
      add_step(0, 1, 32'h0000_0ea4, 4'b1000, 0);
      add_step(1, 0, 32'h0000_0ea4, 4'hf, 0);
      // Scratch registers and the read-only counter
      add_step(0, 1, 32'h9100_0000, 4'hf, 0);
      add_step(0, 1, 32'h9100_0004, 4'hf, 0);
      add_step(1, 1, 32'h9100_0008, 4'hf, 0);
      add_step(1, 1, 32'h9100_0004, 4'b0011, 0);
      add_step(0, 0, 32'h9100_0000, 4'hf, 0);
      add_step(0, 0, 32'h9100_0004, 4'hf, 0);
      add_step(1, 0, 32'h9100_0008, 4'hf, 0);
      add_step(0, 1, 32'h9100_000c, 4'hf, 0);
      add_step(0, 0, 32'h9100_000c, 4'hf, 0);
      // External port and unmapped holes
      add_step(1, 0, 32'h9200_0010, 4'hf, 0);
      add_step(0, 1, 32'h9200_0020, 4'b0110, 0);
      add_step(0, 0, 32'h4000_0000, 4'hf, 0);
      add_step(1, 1, 32'h9300_1000, 4'hf, 0);
      // Silent slave trips the watchdog and bumps the counter
      add_step(0, 0, 32'h9280_0040, 4'hf, 0);
      add_step(1, 0, 32'h9100_000c, 4'hf, 0);
      // Same-cycle start with the processor row first
      add_step(0, 0, 32'h0000_0100, 4'hf, 1);
      add_step(1, 0, 32'h9100_0008, 4'hf, 0);
   endtask

   // Classic single access that returns the ending response
   task automatic bus_access(input step_t s, output dbus_pkg::wb_rsp_t rsp, output logic done);
      dbus_pkg::wb_req_t req;
      int                n;
      req = '{adr: s.adr, dat: s.dat, sel: s.sel, we: s.we, cyc: 1'b1, stb: 1'b1};
      rsp = '0;
      n = 0;
      @(posedge wb_clk);
      #1;
      if (s.master == 0)
         m0_req = req;
      else
         m1_req = req;
      while (!(rsp.ack || rsp.err || rsp.rty) && n < 200) begin
         @(negedge wb_clk);
         rsp = (s.master == 0) ? m0_rsp : m1_rsp;
         n++;
      end
      done = rsp.ack || rsp.err || rsp.rty;
      @(posedge wb_clk);
      #1;
      if (s.master == 0)
         m0_req = '0;
      else
         m1_req = '0;
   endtask

   task automatic run_step(input int k, output time done_t);
      dbus_pkg::wb_rsp_t rsp;
      logic              done;
      step_t             s;
      s = steps[k];
      bus_access(s, rsp, done);
      done_t = $time;
      if (!done) begin
         $display("Row %0d on master %0d got no response within 200 cycles", k, s.master);
         timeout_cnt++;
      end else if (s.exp_err && (!rsp.err || rsp.ack)) begin
         $display("mismatch at %0t: row %0d expected err, got ack %b err %b",
                  $time, k, rsp.ack, rsp.err);
         mismatch_cnt++;
      end else if (!s.exp_err && (!rsp.ack || rsp.err)) begin
         $display("mismatch at %0t: row %0d expected ack, got ack %b err %b",
                  $time, k, rsp.ack, rsp.err);
         mismatch_cnt++;
      end else if (!s.we && !s.exp_err && rsp.dat !== s.exp_dat) begin
         $display("mismatch at %0t: row %0d read %h, expected %h",
                  $time, k, rsp.dat, s.exp_dat);
         mismatch_cnt++;
      end else if (s.adr[31:24] == dbus_pkg::EXT_MATCH &&
                   (ext_seen.adr !== s.adr || ext_seen.we !== s.we ||
                    (s.we && (ext_seen.dat !== s.dat || ext_seen.sel !== s.sel)))) begin
         $display("mismatch at %0t: row %0d external port saw adr %h we %b dat %h sel %b",
                  $time, k, ext_seen.adr, ext_seen.we, ext_seen.dat, ext_seen.sel);
         mismatch_cnt++;
      end
   endtask

   // External slave model that answers on the third stb sample
   initial begin : ext_slave_model
      int wait_cnt;
      wait_cnt = 0;
      ext_seen = '0;
      forever begin
         @(negedge wb_clk);
         if (ext_req.cyc && ext_req.stb && !ext_rsp.ack) begin
            wait_cnt++;
            ext_seen = ext_req;
         end else begin
            wait_cnt = 0;
         end
         @(posedge wb_clk);
         #1;
         ext_rsp = '0;
         if (wait_cnt == 3 && !ext_seen.adr[23]) begin
            ext_rsp.ack = 1'b1;
            ext_rsp.dat = ext_seen.we ? 32'h0 : (ext_seen.adr ^ 32'h5a5a0000);
         end
      end
   end

   initial begin : main_seq
      int  i;
      int  assert_fails;
      time t_m0;
      time t_m1;
      wb_rst       = 1'b1;
      m0_req       = '0;
      m1_req       = '0;
      ext_rsp      = '0;
      mismatch_cnt = 0;
      timeout_cnt  = 0;
      lcg_state    = 32'h29b208cc;
      shadow_tmo   = '0;
      for (int r = 0; r < 3; r++)
         shadow_scr[r] = '0;
      build_table();
      repeat (16) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      i = 0;
      while (i < steps.size()) begin
         if (steps[i].pair && i + 1 < steps.size()) begin
            fork
               run_step(i, t_m0);
               run_step(i + 1, t_m1);
            join
            // Debug master wins the tie
            if (t_m1 >= t_m0) begin
               $display("mismatch at %0t: processor master finished before the debug master",
                        $time);
               mismatch_cnt++;
            end
            i += 2;
         end else begin
            run_step(i, t_m0);
            i++;
         end
      end
      assert_fails = dbus_subsystem_inst.dbus_subsystem_asserts_inst.fail_cnt;
      $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               mismatch_cnt, timeout_cnt, assert_fails);
      if (mismatch_cnt + timeout_cnt + assert_fails == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- dbus_subsystem.f
common/dbus_pkg.sv
dbus_interconnect/dbus_arbiter.sv
dbus_interconnect/dbus_decoder.sv
dbus_interconnect/dbus_watchdog.sv
verilog/wb_ram_slave.sv
verilog/wb_scratch_slave.sv
verilog/dbus_subsystem.sv
testbench/dbus_subsystem_asserts.sv
testbench/tb_dbus_subsystem.sv

//--- Bender.yml
package:
  name: dbus_subsystem

sources:
  - common/dbus_pkg.sv
  - dbus_interconnect/dbus_arbiter.sv
  - dbus_interconnect/dbus_decoder.sv
  - dbus_interconnect/dbus_watchdog.sv
  - verilog/wb_ram_slave.sv
  - verilog/wb_scratch_slave.sv
  - verilog/dbus_subsystem.sv
  - target: test
    files:
      - testbench/dbus_subsystem_asserts.sv
      - testbench/tb_dbus_subsystem.sv
